/* files.f */
rtl/cache_cfg_pkg.sv
rtl/cache_types_pkg.sv
rtl/cache_req_if.sv
rtl/cache_ram.sv
rtl/cache_tag_store.sv
rtl/cache_data_store.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
sim/host_mem_model.sv
sim/cache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module cache_tb -o cache_sim \
    && ./obj_dir/cache_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0

/* sim/cache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_tb;

    localparam logic [31:0] fill_key = 32'h5a5a_0f0f;
    localparam int num_steps = 14;
    localparam int cycle_limit = num_steps * 40 + 8;

    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  hold;      // Cycles of en low during the miss
    } step_t;

    logic clk;
    logic rst_n;
    logic en;
    logic rd;
    logic wr;
    logic [31:0] addr;
    cache_types_pkg::word_t wdata;
    cache_types_pkg::word_t rdata;
    logic hit_out;
    logic stall;
    logic done;
    cache_types_pkg::host_op_t host_op;
    logic [31:0] host_addr;
    cache_types_pkg::line_t host_wline;
    cache_types_pkg::line_t host_rline;
    logic host_done;

    step_t steps [num_steps];
    cache_types_pkg::word_t words [logic [29:0]];  // Words stored by the CPU
    logic [17:0] set_tag [256];
    bit set_valid [256];
    bit set_dirty [256];
    int errors;
    int wb_errors;
    int cycles;
    int n_rd;
    int n_wr;
    int rd_before_wr;   // Host reads seen when the last write-back ended
    logic [31:0] last_rd_addr;
    logic [31:0] last_wr_addr;

    cache_top uut (
        .clk (clk), .rst_n (rst_n), .en (en), .rd (rd), .wr (wr), .addr (addr),
        .wdata (wdata), .rdata (rdata), .hit_out (hit_out), .stall (stall), .done (done),
        .host_op (host_op), .host_addr (host_addr), .host_wline (host_wline),
        .host_rline (host_rline), .host_done (host_done)
    );

    host_mem_model #(.fill_key (fill_key)) u_host (
        .clk (clk), .rst_n (rst_n), .host_op (host_op), .host_addr (host_addr),
        .host_wline (host_wline), .host_rline (host_rline), .host_done (host_done)
    );

    function automatic cache_types_pkg::word_t model_word(input logic [31:0] a);
        return words.exists(a[31:2]) ? words[a[31:2]] : ({a[31:2], 2'b00} ^ fill_key);
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the table did not finish", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // Host transfers, written lines checked against the CPU view
    always @(negedge clk) begin
        if (rst_n && host_done) begin
            if (host_op == cache_types_pkg::host_write) begin
                n_wr = n_wr + 1;
                rd_before_wr = n_rd;
                last_wr_addr = host_addr;
                for (int i = 0; i < 16; i++) begin
                    if (host_wline[i*32 +: 32] != model_word(host_addr + 32'(i * 4))) begin
                        $display("Fail %0t: host_wline word %0d expected %h got %h", $time, i,
                                 model_word(host_addr + 32'(i * 4)), host_wline[i*32 +: 32]);
                        wb_errors = wb_errors + 1;
                    end
                end
            end else begin
                n_rd = n_rd + 1;
                last_rd_addr = host_addr;
            end
        end
    end

    initial begin
        step_t s;
        logic [7:0] set_idx;
        logic [17:0] tag;
        logic exp_hit;
        logic exp_wb;
        logic [31:0] victim;
        int n_rd0;
        int n_wr0;
        int rd_cnt;
        int wr_cnt;
        int exp_rd;
        int wait_cycles;
        rst_n = 1'b0;
        en    = 1'b0;
        rd    = 1'b0;
        wr    = 1'b0;
        addr  = '0;
        wdata = '0;
        errors = 0;
        steps[0]  = '{1'b0, 32'h0000_1040, 32'h0000_0000, 4'd0};  // Read miss, clean set
        steps[1]  = '{1'b0, 32'h0000_1044, 32'h0000_0000, 4'd0};
        steps[2]  = '{1'b1, 32'h0000_1048, 32'hdead_beef, 4'd0};  // Write hit
        steps[3]  = '{1'b0, 32'h0000_1048, 32'h0000_0000, 4'd0};
        steps[4]  = '{1'b0, 32'h0000_104c, 32'h0000_0000, 4'd0};
        steps[5]  = '{1'b1, 32'h0000_2080, 32'h1234_5678, 4'd0};  // Write miss
        steps[6]  = '{1'b0, 32'h0000_2080, 32'h0000_0000, 4'd0};
        steps[7]  = '{1'b0, 32'h0000_2084, 32'h0000_0000, 4'd0};
        steps[8]  = '{1'b0, 32'h0004_1040, 32'h0000_0000, 4'd0};  // Dirty victim out
        steps[9]  = '{1'b0, 32'h0000_1048, 32'h0000_0000, 4'd0};
        steps[10] = '{1'b1, 32'h0008_2080, 32'hcafe_f00d, 4'd6};  // en dropped mid miss
        steps[11] = '{1'b0, 32'h0008_2080, 32'h0000_0000, 4'd0};
        steps[12] = '{1'b0, 32'h0000_2084, 32'h0000_0000, 4'd0};
        steps[13] = '{1'b0, 32'h0000_2080, 32'h0000_0000, 4'd0};
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        if (stall || done || hit_out) begin
            $display("Fail %0t: stall/done/hit_out expected 0/0/0 got %b/%b/%b", $time,
                     stall, done, hit_out);
            errors = errors + 1;
        end
        if (host_op != cache_types_pkg::host_none) begin
            $display("Fail %0t: host_op expected %0d got %0d", $time,
                     cache_types_pkg::host_none, host_op);
            errors = errors + 1;
        end
        for (int k = 0; k < num_steps; k++) begin
            s = steps[k];
            set_idx = s.addr[13:6];
            tag     = s.addr[31:14];
            exp_hit = set_valid[set_idx] && set_tag[set_idx] == tag;
            exp_wb  = !exp_hit && set_valid[set_idx] && set_dirty[set_idx];
            exp_rd  = exp_hit ? 0 : 1;
            victim  = {set_tag[set_idx], set_idx, 6'b0};
            n_rd0   = n_rd;
            n_wr0   = n_wr;
            if (stall) begin
                $display("Fail %0t: stall expected 0 got %b before step %0d", $time, stall, k);
                errors = errors + 1;
            end
            en    = 1'b1;
            rd    = !s.wr;
            wr    = s.wr;
            addr  = s.addr;
            wdata = s.wdata;
            @(posedge clk);
            #1;
            rd = 1'b0;
            wr = 1'b0;
            wait_cycles = 1;
            while (!done) begin
                if (s.hold != 4'd0 && wait_cycles == 2) begin
                    en = 1'b0;
                    repeat (s.hold) begin
                        @(posedge clk);
                        #1;
                        if (!stall || done) begin
                            $display("Fail %0t: stall/done expected 1/0 got %b/%b", $time,
                                     stall, done);
                            errors = errors + 1;
                        end
                    end
                    en = 1'b1;
                    wait_cycles = wait_cycles + int'(s.hold);
                    #1;     // done may rise as soon as en returns
                end else begin
                    @(posedge clk);
                    #1;
                    wait_cycles = wait_cycles + 1;
                end
            end
            rd_cnt = n_rd - n_rd0;
            wr_cnt = n_wr - n_wr0;
            if (!s.wr && rdata !== model_word(s.addr)) begin
                $display("Fail %0t: rdata expected %h got %h", $time, model_word(s.addr), rdata);
                errors = errors + 1;
            end
            if (hit_out !== exp_hit) begin
                $display("Fail %0t: hit_out expected %b got %b", $time, exp_hit, hit_out);
                errors = errors + 1;
            end
            if (exp_hit && wait_cycles != 1) begin
                $display("Fail %0t: hit latency expected 1 got %0d", $time, wait_cycles);
                errors = errors + 1;
            end
            if (s.hold == 4'd0 ? rd_cnt != exp_rd : (rd_cnt == 0) != (exp_rd == 0)) begin
                $display("Fail %0t: host reads expected %0d got %0d", $time, exp_rd, rd_cnt);
                errors = errors + 1;
            end
            if (exp_rd != 0 && last_rd_addr != {s.addr[31:6], 6'b0}) begin
                $display("Fail %0t: host read addr expected %h got %h", $time,
                         {s.addr[31:6], 6'b0}, last_rd_addr);
                errors = errors + 1;
            end
            if (s.hold == 4'd0 ? wr_cnt != int'(exp_wb) : (wr_cnt != 0) != exp_wb) begin
                $display("Fail %0t: host writes expected %0d got %0d", $time, exp_wb, wr_cnt);
                errors = errors + 1;
            end
            if (exp_wb && last_wr_addr != victim) begin
                $display("Fail %0t: host write addr expected %h got %h", $time, victim,
                         last_wr_addr);
                errors = errors + 1;
            end
            if (exp_wb && wr_cnt != 0 && rd_before_wr != n_rd0) begin
                $display("Fail %0t: write-back of the victim came after the line fill", $time);
                errors = errors + 1;
            end
            set_valid[set_idx] = 1'b1;
            set_tag[set_idx]   = tag;
            if (!exp_hit) begin
                set_dirty[set_idx] = 1'b0;
            end
            if (s.wr) begin
                words[s.addr[31:2]] = s.wdata;
                set_dirty[set_idx]  = 1'b1;
            end
            @(posedge clk);     // Back to idle
            #1;
        end
        $display("Checks done: %0d errors, %0d write-back errors", errors, wb_errors);
        if (errors == 0 && wb_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/host_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module host_mem_model #(
    parameter logic [31:0] fill_key = 32'h5a5a_0f0f
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire cache_types_pkg::host_op_t host_op,
    input  wire logic [31:0]               host_addr,
    input  wire cache_types_pkg::line_t    host_wline,
    output      cache_types_pkg::line_t    host_rline,
    output      logic                      host_done
);

    cache_types_pkg::line_t lines [logic [25:0]];   // Lines written back so far
    logic [31:0] lfsr;
    logic [3:0] wait_cnt;
    logic busy;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Untouched memory holds each word's byte address XOR the key
    function automatic cache_types_pkg::line_t initial_line(input logic [25:0] line_addr);
        cache_types_pkg::line_t l;
        for (int i = 0; i < cache_cfg_pkg::words_per_line; i++) begin
            l[i*32 +: 32] = ({line_addr, 6'b0} + 32'(i * 4)) ^ fill_key;
        end
        return l;
    endfunction

    always @(posedge clk or negedge rst_n) begin : serve
        logic [2:0] lat;
        if (!rst_n) begin
            lfsr = 32'heacb_63b6;
            busy       <= 1'b0;
            wait_cnt   <= 4'd0;
            host_done  <= 1'b0;
            host_rline <= '0;
        end else begin
            host_done <= 1'b0;
            if (busy) begin
                if (wait_cnt == 4'd1) begin
                    busy      <= 1'b0;
                    host_done <= 1'b1;
                    if (host_op == cache_types_pkg::host_write) begin
                        lines[host_addr[31:6]] = host_wline;
                    end
                    host_rline <= lines.exists(host_addr[31:6]) ? lines[host_addr[31:6]]
                                                                : initial_line(host_addr[31:6]);
                end else begin
                    wait_cnt <= wait_cnt - 4'd1;
                end
            end else if (!host_done && host_op != cache_types_pkg::host_none) begin
                // Three LFSR steps, one bit each, give 2 to 9 cycles
                lat = 3'd0;
                for (int b = 0; b < 3; b++) begin
                    lfsr = lfsr_step(lfsr);
                    lat  = {lat[1:0], lfsr[0]};
                end
                busy     <= 1'b1;
                wait_cnt <= 4'd2 + {1'b0, lat};
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/cache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_top (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    // CPU load/store port
    input  wire logic                             en,
    input  wire logic                             rd,
    input  wire logic                             wr,
    input  wire logic [cache_cfg_pkg::addr_w-1:0] addr,
    input  wire cache_types_pkg::word_t           wdata,
    output      cache_types_pkg::word_t           rdata,
    output      logic                             hit_out,
    output      logic                             stall,
    output      logic                             done,
    // Host memory controller
    output      cache_types_pkg::host_op_t        host_op,
    output      logic [cache_cfg_pkg::addr_w-1:0] host_addr,
    output      cache_types_pkg::line_t           host_wline,
    input  wire cache_types_pkg::line_t           host_rline,
    input  wire logic                             host_done
);

    logic hit;
    logic dirty;
    logic [cache_cfg_pkg::tag_w-1:0] victim_tag;
    cache_types_pkg::word_t rword;
    cache_types_pkg::line_t victim_line;

    cache_req_if req_if ();

    cache_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .rd          (rd),
        .wr          (wr),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .hit_out     (hit_out),
        .stall       (stall),
        .done        (done),
        .req         (req_if.ctrl),
        .hit         (hit),
        .dirty       (dirty),
        .victim_tag  (victim_tag),
        .rword       (rword),
        .victim_line (victim_line),
        .host_op     (host_op),
        .host_addr   (host_addr),
        .host_wline  (host_wline),
        .host_rline  (host_rline),
        .host_done   (host_done)
    );

    cache_tag_store u_tag_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req_if.tag),
        .hit        (hit),
        .dirty      (dirty),
        .victim_tag (victim_tag)
    );

    cache_data_store u_data_store (
        .clk         (clk),
        .req         (req_if.data),
        .rword       (rword),
        .victim_line (victim_line)
    );

endmodule

`default_nettype wire

/* rtl/cache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    // CPU side
    input  wire logic                             en,
    input  wire logic                             rd,
    input  wire logic                             wr,
    input  wire logic [cache_cfg_pkg::addr_w-1:0] addr,
    input  wire cache_types_pkg::word_t           wdata,
    output      cache_types_pkg::word_t           rdata,
    output      logic                             hit_out,
    output      logic                             stall,
    output      logic                             done,
    // Stores
    cache_req_if.ctrl                             req,
    input  wire logic                             hit,
    input  wire logic                             dirty,
    input  wire logic [cache_cfg_pkg::tag_w-1:0]  victim_tag,
    input  wire cache_types_pkg::word_t           rword,
    input  wire cache_types_pkg::line_t           victim_line,
    // Host side
    output      cache_types_pkg::host_op_t        host_op,
    output      logic [cache_cfg_pkg::addr_w-1:0] host_addr,
    output      cache_types_pkg::line_t           host_wline,
    input  wire cache_types_pkg::line_t           host_rline,
    input  wire logic                             host_done
);

    localparam int offset_w = cache_cfg_pkg::offset_w;
    localparam int index_w = cache_cfg_pkg::index_w;
    localparam int tag_w = cache_cfg_pkg::tag_w;

    cache_types_pkg::ctrl_state_t state;
    cache_types_pkg::ctrl_state_t next_state;

    logic [cache_cfg_pkg::addr_w-1:0] addr_q;
    cache_types_pkg::word_t wdata_q;
    logic rd_q;
    logic miss_q;       // Request already missed once
    logic start;
    logic word_wr;
    logic line_fill;

    assign start = (state == cache_types_pkg::idle) && en && (rd || wr);

    // Request held for the whole transaction
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= addr;
            wdata_q <= wdata;
            rd_q    <= rd;      // Read wins over write
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= cache_types_pkg::idle;
            miss_q <= 1'b0;
        end else if (en) begin
            state <= next_state;
            if (state == cache_types_pkg::idle) begin
                miss_q <= 1'b0;
            end else if (((state == cache_types_pkg::cmp_rd) ||
                          (state == cache_types_pkg::cmp_wr)) && !hit) begin
                miss_q <= 1'b1;
            end
        end
    end

    assign req.addr_tag = addr_q[cache_cfg_pkg::addr_w-1 -: tag_w];
    assign req.index    = addr_q[offset_w +: index_w];
    assign req.offset   = addr_q[offset_w-1:0];
    assign req.wdata    = wdata_q;
    assign req.fill     = host_rline;
    assign req.lookup = (state == cache_types_pkg::cmp_rd) || (state == cache_types_pkg::cmp_wr);
    assign req.word_wr   = word_wr;
    assign req.line_fill = line_fill;

    always_comb begin
        next_state = state;
        stall      = 1'b1;
        done       = 1'b0;
        hit_out    = 1'b0;
        rdata      = '0;
        word_wr    = 1'b0;
        line_fill  = 1'b0;
        host_op    = cache_types_pkg::host_none;
        host_addr  = '0;
        host_wline = '0;
        case (state)
            cache_types_pkg::idle: begin
                stall = 1'b0;
                if (rd) begin
                    next_state = cache_types_pkg::cmp_rd;
                end else if (wr) begin
                    next_state = cache_types_pkg::cmp_wr;
                end
            end
            cache_types_pkg::cmp_rd: begin
                if (hit) begin
                    done       = en;
                    hit_out    = en & ~miss_q;  // Low when the line was just filled
                    rdata      = rword;
                    next_state = cache_types_pkg::idle;
                end else begin
                    next_state = dirty ? cache_types_pkg::mem_wb : cache_types_pkg::mem_rd;
                end
            end
            cache_types_pkg::cmp_wr: begin
                if (hit) begin
                    word_wr    = en;
                    done       = en;
                    hit_out    = en;
                    next_state = cache_types_pkg::idle;
                end else begin
                    next_state = dirty ? cache_types_pkg::mem_wb : cache_types_pkg::mem_rd;
                end
            end
            cache_types_pkg::mem_wb: begin
                host_op    = cache_types_pkg::host_write;
                host_addr  = {victim_tag, req.index, {offset_w{1'b0}}};
                host_wline = victim_line;
                if (host_done) begin
                    next_state = cache_types_pkg::mem_rd;
                end
            end
            cache_types_pkg::mem_rd: begin
                host_op   = cache_types_pkg::host_read;
                host_addr = {req.addr_tag, req.index, {offset_w{1'b0}}};
                if (host_done) begin
                    line_fill  = en;    // Fill data only valid in this cycle
                    next_state = rd_q ? cache_types_pkg::cmp_rd : cache_types_pkg::cache_wr;
                end
            end
            cache_types_pkg::cache_wr: begin
                word_wr    = en;
                done       = en;
                next_state = cache_types_pkg::idle;
            end
            default: begin
                next_state = cache_types_pkg::idle;
            end
        endcase
    end

    a_stall_on_host: assert property (@(posedge clk) disable iff (!rst_n)
        (host_op != cache_types_pkg::host_none) |-> stall)
        else $error("host request without stall");

    // Host sees one steady request until it answers
    a_host_op_held: assert property (@(posedge clk) disable iff (!rst_n)
        ((host_op != cache_types_pkg::host_none) && !host_done) |=> (host_op == $past(host_op)))
        else $error("host_op changed before host_done");

endmodule

`default_nettype wire

/* rtl/cache_data_store.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_data_store (
    input  wire logic       clk,
    cache_req_if.data       req,
    output cache_types_pkg::word_t rword,
    output cache_types_pkg::line_t victim_line
);

    localparam int sel_w = $clog2(cache_cfg_pkg::words_per_line);
    localparam int word_w = cache_cfg_pkg::word_w;

    cache_types_pkg::line_t rline;
    cache_types_pkg::line_t merged;
    cache_types_pkg::line_t wline;
    logic [sel_w-1:0] word_sel;
    logic we;

    // Word number inside the line, byte bits dropped
    assign word_sel = req.offset[cache_cfg_pkg::offset_w-1 -: sel_w];

    always_comb begin
        merged = rline;
        merged[word_sel*word_w +: word_w] = req.wdata;
    end

    assign wline = req.line_fill ? req.fill : merged;
    assign we    = req.line_fill | req.word_wr;

    cache_ram #(
        .entry_t (cache_types_pkg::line_t)
    ) u_line_ram (
        .clk    (clk),
        .we     (we),
        .waddr  (req.index),
        .wentry (wline),
        .raddr  (req.index),
        .rentry (rline)
    );

    assign rword       = rline[word_sel*word_w +: word_w];
    assign victim_line = rline;     // Whole line for write-back

endmodule

`default_nettype wire

/* rtl/cache_tag_store.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_tag_store (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    cache_req_if.tag                             req,
    output      logic                            hit,
    output      logic                            dirty,
    output      logic [cache_cfg_pkg::tag_w-1:0] victim_tag
);

    cache_types_pkg::tag_entry_t rd_entry;
    cache_types_pkg::tag_entry_t wr_entry;
    logic [cache_cfg_pkg::num_sets-1:0] valid_vec;
    logic valid;
    logic we;

    assign we = req.line_fill | req.word_wr;

    // Fill leaves the line clean, a word write marks it dirty
    always_comb begin
        wr_entry.valid = 1'b1;
        wr_entry.dirty = req.word_wr;
        wr_entry.tag   = req.addr_tag;
    end

    cache_ram #(
        .entry_t (cache_types_pkg::tag_entry_t)
    ) u_tag_ram (
        .clk    (clk),
        .we     (we),
        .waddr  (req.index),
        .wentry (wr_entry),
        .raddr  (req.index),
        .rentry (rd_entry)
    );

    // Valid bits live in flops so the array starts empty after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_vec <= '0;
        end else if (we) begin
            valid_vec[req.index] <= 1'b1;
        end
    end

    assign valid      = valid_vec[req.index] & rd_entry.valid;
    assign hit        = req.lookup & valid & (rd_entry.tag == req.addr_tag);
    assign dirty      = valid & rd_entry.dirty;     // Victim needs write-back
    assign victim_tag = rd_entry.tag;

    a_one_write_kind: assert property (@(posedge clk) disable iff (!rst_n)
        !(req.line_fill && req.word_wr))
        else $error("line_fill and word_wr in the same cycle");

endmodule

`default_nettype wire

/* rtl/cache_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_ram #(
    parameter type entry_t = logic
) (
    input  wire logic                              clk,
    input  wire logic                              we,
    input  wire logic [cache_cfg_pkg::index_w-1:0] waddr,
    input  wire entry_t                            wentry,
    input  wire logic [cache_cfg_pkg::index_w-1:0] raddr,
    output      entry_t                            rentry
);

    localparam int depth = cache_cfg_pkg::num_sets;

    entry_t mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wentry;
        end
    end

    assign rentry = mem[raddr];     // Read is combinational

    // A write to an unknown set would corrupt an arbitrary line
    a_waddr_known: assert property (@(posedge clk) we |-> !$isunknown(waddr))
        else $error("cache_ram write with unknown address");

endmodule

`default_nettype wire

/* rtl/cache_req_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface cache_req_if;

    // Fields of the held request
    logic [cache_cfg_pkg::index_w-1:0]  index;
    logic [cache_cfg_pkg::tag_w-1:0]    addr_tag;
    logic [cache_cfg_pkg::offset_w-1:0] offset;

    cache_types_pkg::word_t wdata;
    cache_types_pkg::line_t fill;       // Line returned by host

    logic word_wr;      // Write one word, mark dirty
    logic line_fill;    // Replace line, valid and clean
    logic lookup;       // Tag compare in progress

    modport ctrl (output index, addr_tag, offset, wdata, fill, word_wr, line_fill, lookup);

    modport tag (input index, addr_tag, word_wr, line_fill, lookup);

    modport data (input index, offset, wdata, fill, word_wr, line_fill);

endinterface

`default_nettype wire

/* rtl/cache_types_pkg.sv */
`default_nettype none

package cache_types_pkg;

    typedef logic [cache_cfg_pkg::word_w-1:0] word_t;
    typedef logic [cache_cfg_pkg::line_w-1:0] line_t;

    // One entry of the tag array
    typedef struct packed {
        logic                            valid;
        logic                            dirty;   // Line differs from host memory
        logic [cache_cfg_pkg::tag_w-1:0] tag;
    } tag_entry_t;

    // Codes seen by the host memory controller
    typedef enum logic [1:0] {
        host_none  = 2'd0,
        host_read  = 2'd1,
        host_write = 2'd3
    } host_op_t;

    typedef enum logic [2:0] {
        idle,
        cmp_rd,     // Lookup for a load
        cmp_wr,     // Lookup and word write for a store
        mem_wb,     // Victim line out to host
        mem_rd,     // Line fill from host
        cache_wr    // Word merge after a store miss
    } ctrl_state_t;

endpackage

`default_nettype wire

/* rtl/cache_cfg_pkg.sv */
`default_nettype none

package cache_cfg_pkg;

    // CPU side
    localparam int addr_w = 32;
    localparam int word_w = 32;

    // Line geometry
    localparam int line_w = 512;
    localparam int offset_w = $clog2(line_w / 8);   // Byte offset in a line
    localparam int words_per_line = line_w / word_w;

    // Set and tag split of the address
    localparam int index_w = 8;
    localparam int num_sets = 1 << index_w;
    localparam int tag_w = addr_w - index_w - offset_w;

endpackage

`default_nettype wire
